// File: common/lsu_pkg.sv
// Load/store unit shared types
// Request, bank write and writeback structs for the LSU and its data memory

package lsu_pkg;

	// Rename buffer bits appended to the register number
	parameter int rb_w = 2;

	// Full destination tag
	parameter int rd_tag_w = 5 + rb_w;

	// Load access size
	typedef enum logic [1:0] {
		lb,
		lh,
		lw,
		ld
	} load_op_e;

	// Store access size
	typedef enum logic [1:0] {
		sb,
		sh,
		sw,
		sd
	} store_op_e;

	// Load request from execute
	typedef struct packed {
		load_op_e op;
		logic [rd_tag_w-1:0] rd;
		// Byte address, any alignment
		logic [63:0] addr;
		// Zero extend instead of sign extend
		logic is_unsigned;
	} load_req_t;

	// Store request from execute
	typedef struct packed {
		store_op_e op;
		logic [63:0] addr;
		// Store data, right aligned
		logic [63:0] data;
	} store_req_t;

	// Write port of one memory bank
	typedef struct packed {
		logic wen;
		// One bit per byte lane
		logic [7:0] wmask;
		logic [63:0] wdata;
	} bank_wr_t;

	// Result returned to the register file
	typedef struct packed {
		logic [rd_tag_w-1:0] rd;
		logic [63:0] result;
	} wb_t;

endpackage

// File: source/dtcm.sv
`timescale 1ns/1ns
// Tightly coupled data memory bank, 64 bits wide
// Synchronous read and byte-masked synchronous write

module dtcm #(
	parameter int aw = 10
) (
	input logic CLK,
	input logic reset,
	input logic [aw-1:0] addr,
	input lsu_pkg::bank_wr_t wr,
	output logic [63:0] rdata
);

	// Doubleword storage
	logic [63:0] mem [0:(2**aw)-1];

	// Byte lane writes
	always_ff @(posedge CLK) begin
		if (wr.wen) begin
			for (int i = 0; i < 8; i++) begin
				// Only lanes with mask set
				if (wr.wmask[i]) begin
					mem[addr][8*i +: 8] <= wr.wdata[8*i +: 8];
				end
			end
		end
	end

	// Registered read
	// Same-index write in this cycle is not visible yet, old data comes out
	always_ff @(posedge CLK) begin
		if (reset) begin
			rdata <= '0;
		end else begin
			rdata <= mem[addr];
		end
	end

	// Mask must be quiet without a write enable
	// The mask is built upstream in store_align
	a_mask_needs_wen: assert property (
		@(posedge CLK) disable iff (reset)
		!wr.wen |-> (wr.wmask == 8'h00)
	);

endmodule

// File: lsu/store_align.sv
`timescale 1ns/1ns
// Store alignment
// Spreads one store over the two banks as byte masks and shifted data

module store_align (
	input lsu_pkg::store_req_t req,
	input logic en,
	output lsu_pkg::bank_wr_t wr_a,
	output lsu_pkg::bank_wr_t wr_b
);

	import lsu_pkg::*;

	// Byte offset within the doubleword
	logic [2:0] offset;
	// Mask for the size before shifting
	logic [15:0] size_mask;
	// Mask over the 16 byte window
	logic [15:0] mask;
	// Data over the 16 byte window
	logic [127:0] wide_data;
	// Lower and upper doubleword of the window
	logic [7:0] lo_mask;
	logic [7:0] hi_mask;
	logic [63:0] lo_data;
	logic [63:0] hi_data;

	assign offset = req.addr[2:0];

	always_comb begin
		case (req.op)
			sb: size_mask = 16'h0001;
			sh: size_mask = 16'h0003;
			sw: size_mask = 16'h000f;
			// sd
			default: size_mask = 16'h00ff;
		endcase
	end

	// Shift into place, may spill into upper doubleword
	assign mask = size_mask << offset;
	assign wide_data = {64'h0, req.data} << {offset, 3'b000};

	// Masks only live when the store is granted
	assign lo_mask = mask[7:0] & {8{en}};
	assign hi_mask = mask[15:8] & {8{en}};
	assign lo_data = wide_data[63:0];
	assign hi_data = wide_data[127:64];

	// Bit 3 says which bank holds the lower doubleword
	always_comb begin
		wr_a.wen = en;
		wr_b.wen = en;
		if (req.addr[3]) begin
			// Odd start, lower half in bank B
			wr_b.wmask = lo_mask;
			wr_b.wdata = lo_data;
			wr_a.wmask = hi_mask;
			wr_a.wdata = hi_data;
		end else begin
			wr_a.wmask = lo_mask;
			wr_a.wdata = lo_data;
			wr_b.wmask = hi_mask;
			wr_b.wdata = hi_data;
		end
	end

endmodule

// File: lsu/load_extract.sv
`timescale 1ns/1ns
// Load data extraction
// Selects the addressed bytes from both banks and extends to 64 bits

module load_extract (
	input lsu_pkg::load_op_e op,
	input logic [3:0] offset,
	input logic is_unsigned,
	input logic [63:0] rdata_a,
	input logic [63:0] rdata_b,
	output logic [63:0] result
);

	import lsu_pkg::*;

	// 16 byte window, lower doubleword first
	logic [127:0] window;
	// Addressed bytes moved down to bit 0
	logic [63:0] shifted;

	// Bank B holds the lower doubleword on an odd start
	assign window = offset[3] ? {rdata_a, rdata_b} : {rdata_b, rdata_a};

	// Byte offset times eight
	assign shifted = window[{offset[2:0], 3'b000} +: 64];

	always_comb begin
		case (op)
			lb: begin
				if (is_unsigned) begin
					result = {56'h0, shifted[7:0]};
				end else begin
					result = {{56{shifted[7]}}, shifted[7:0]};
				end
			end
			lh: begin
				if (is_unsigned) begin
					result = {48'h0, shifted[15:0]};
				end else begin
					result = {{48{shifted[15]}}, shifted[15:0]};
				end
			end
			lw: begin
				if (is_unsigned) begin
					result = {32'h0, shifted[31:0]};
				end else begin
					result = {{32{shifted[31]}}, shifted[31:0]};
				end
			end
			// ld, full width, no extension
			default: begin
				result = shifted;
			end
		endcase
	end

endmodule

// File: lsu/lsu.sv
`timescale 1ns/1ns
// Load/store unit
// Load over store arbitration, bank addressing and one cycle writeback

module lsu #(
	parameter int aw = 10
) (
	input logic CLK,
	input logic reset,

	// Load channel
	input lsu_pkg::load_req_t lu_req,
	input logic lu_valid,
	output logic lu_ready,

	// Store channel
	input lsu_pkg::store_req_t su_req,
	input logic su_valid,
	output logic su_ready,

	// Memory banks
	output logic [aw-1:0] bank_a_addr,
	output logic [aw-1:0] bank_b_addr,
	output lsu_pkg::bank_wr_t bank_a_wr,
	output lsu_pkg::bank_wr_t bank_b_wr,
	input logic [63:0] bank_a_rdata,
	input logic [63:0] bank_b_rdata,

	// Writeback
	output lsu_pkg::wb_t wb,
	output logic wb_valid
);

	import lsu_pkg::*;

	// Transfers this cycle
	logic load_grant;
	logic store_grant;
	// Address of the winning request
	logic [63:0] grant_addr;
	// Doubleword indices of the 16 byte window
	logic [aw-1:0] lo_idx;
	logic [aw-1:0] hi_idx;

	// Load info held for the data cycle
	load_op_e ld_op_q;
	logic [3:0] ld_offset_q;
	logic ld_unsigned_q;
	logic [rd_tag_w-1:0] ld_rd_q;
	logic ld_grant_q;
	// Any transfer last cycle
	logic valid_q;
	// Extended load data
	logic [63:0] ld_result;

	// Memory never stalls
	assign lu_ready = 1'b1;
	// Load wins the cycle
	assign su_ready = ~lu_valid;

	assign load_grant = lu_valid & lu_ready;
	assign store_grant = su_valid & su_ready;

	// Bank indices from the granted address
	assign grant_addr = load_grant ? lu_req.addr : su_req.addr;
	assign lo_idx = grant_addr[3 +: aw];
	// Wraps at bank depth
	assign hi_idx = lo_idx + 1'b1;
	assign bank_a_addr = grant_addr[3] ? hi_idx : lo_idx;
	assign bank_b_addr = grant_addr[3] ? lo_idx : hi_idx;

	// Store masks and data, written at the accepting edge
	store_align store_align_i (
		.req (su_req),
		.en  (store_grant),
		.wr_a(bank_a_wr),
		.wr_b(bank_b_wr)
	);

	always_ff @(posedge CLK) begin
		if (reset) begin
			valid_q <= 1'b0;
			ld_grant_q <= 1'b0;
			ld_op_q <= lb;
			ld_offset_q <= '0;
			ld_unsigned_q <= 1'b0;
			ld_rd_q <= '0;
		end else begin
			valid_q <= load_grant | store_grant;
			ld_grant_q <= load_grant;
			// Store completes with tag zero
			ld_rd_q <= load_grant ? lu_req.rd : '0;
			if (load_grant) begin
				ld_op_q <= lu_req.op;
				ld_offset_q <= lu_req.addr[3:0];
				ld_unsigned_q <= lu_req.is_unsigned;
			end
		end
	end

	// Bank data arrives the cycle after the address
	load_extract load_extract_i (
		.op         (ld_op_q),
		.offset     (ld_offset_q),
		.is_unsigned(ld_unsigned_q),
		.rdata_a    (bank_a_rdata),
		.rdata_b    (bank_b_rdata),
		.result     (ld_result)
	);

	// Zero result for stores
	always_comb begin
		wb.rd = ld_rd_q;
		wb.result = ld_grant_q ? ld_result : 64'h0;
	end

	assign wb_valid = valid_q;

	// No bank write may slip in beside a pending load
	a_load_priority: assert property (
		@(posedge CLK) disable iff (reset)
		lu_valid |-> !(bank_a_wr.wen || bank_b_wr.wen)
	);

	// Writeback only follows a handshake
	a_wb_after_transfer: assert property (
		@(posedge CLK) disable iff (reset)
		wb_valid |-> $past((lu_valid && lu_ready) || (su_valid && su_ready))
	);

endmodule

// File: source/lsu_top.sv
`timescale 1ns/1ns
// Load/store subsystem top
// LSU with its two interleaved data memory banks

module lsu_top #(
	parameter int aw = 10
) (
	input logic CLK,
	input logic reset,
	input lsu_pkg::load_req_t lu_req,
	input logic lu_valid,
	output logic lu_ready,
	input lsu_pkg::store_req_t su_req,
	input logic su_valid,
	output logic su_ready,
	output lsu_pkg::wb_t wb,
	output logic wb_valid
);

	import lsu_pkg::*;

	// Bank A even doublewords, bank B odd
	logic [aw-1:0] bank_a_addr;
	logic [aw-1:0] bank_b_addr;
	bank_wr_t bank_a_wr;
	bank_wr_t bank_b_wr;
	logic [63:0] bank_a_rdata;
	logic [63:0] bank_b_rdata;

	lsu #(.aw(aw)) lsu_i (
		.CLK         (CLK),
		.reset       (reset),
		.lu_req      (lu_req),
		.lu_valid    (lu_valid),
		.lu_ready    (lu_ready),
		.su_req      (su_req),
		.su_valid    (su_valid),
		.su_ready    (su_ready),
		.bank_a_addr (bank_a_addr),
		.bank_b_addr (bank_b_addr),
		.bank_a_wr   (bank_a_wr),
		.bank_b_wr   (bank_b_wr),
		.bank_a_rdata(bank_a_rdata),
		.bank_b_rdata(bank_b_rdata),
		.wb          (wb),
		.wb_valid    (wb_valid)
	);

	dtcm #(.aw(aw)) bank_a_i (
		.CLK  (CLK),
		.reset(reset),
		.addr (bank_a_addr),
		.wr   (bank_a_wr),
		.rdata(bank_a_rdata)
	);

	dtcm #(.aw(aw)) bank_b_i (
		.CLK  (CLK),
		.reset(reset),
		.addr (bank_b_addr),
		.wr   (bank_b_wr),
		.rdata(bank_b_rdata)
	);

endmodule

// File: dv/lsu_tb.sv
`timescale 1ns/1ns
// Load/store unit testbench
// Table of stores and loads checked against a byte-array reference memory

module lsu_tb;

	import lsu_pkg::*;

	// Kind of table entry
	typedef enum {k_store, k_load, k_pair} kind_e;

	// One table row
	typedef struct {
		string name;
		kind_e kind;
		int size;
		logic [63:0] addr;
		logic [63:0] data;
		bit is_unsigned;
		logic [rd_tag_w-1:0] rd;
		logic [63:0] expected;
	} vec_t;

	logic CLK;
	logic reset;
	load_req_t lu_req;
	logic lu_valid;
	logic lu_ready;
	store_req_t su_req;
	logic su_valid;
	logic su_ready;
	wb_t wb;
	logic wb_valid;

	vec_t vecs[$];
	// Byte-addressed model of the low part of memory
	logic [7:0] ref_mem [0:1023];
	int seed = 32'h73ce_3d94;
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 0;

	lsu_top #(.aw(10)) dut_i (
		.CLK     (CLK),
		.reset   (reset),
		.lu_req  (lu_req),
		.lu_valid(lu_valid),
		.lu_ready(lu_ready),
		.su_req  (su_req),
		.su_valid(su_valid),
		.su_ready(su_ready),
		.wb      (wb),
		.wb_valid(wb_valid)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// Watchdog with its limit set once the table is built
	initial begin
		do begin
			@(posedge CLK);
			cycles++;
		end while (cycles < cycle_limit);
		$display("timeout: run still busy after %0d cycles", cycles);
		$display("Checks failed");
		$finish;
	end

	function automatic logic [63:0] random_dword();
		return {$random(seed), $random(seed)};
	endfunction

	// Little endian read with sign or zero extension
	function automatic logic [63:0] ref_load(input int size, input int addr, input bit uns);
		logic [63:0] raw;
		int n;
		raw = '0;
		n = 1 << size;
		for (int k = 0; k < n; k++) begin
			raw[8*k +: 8] = ref_mem[addr + k];
		end
		// Fill the upper bytes with the sign bit
		if (!uns && n < 8 && raw[8*n-1]) begin
			raw = raw | (~64'h0 << (8*n));
		end
		return raw;
	endfunction

	function automatic void ref_store(input int size, input int addr, input logic [63:0] data);
		for (int k = 0; k < (1 << size); k++) begin
			ref_mem[addr + k] = data[8*k +: 8];
		end
	endfunction

	// Expected value taken before the store of a pair lands
	function automatic void add_vec(input string name, input kind_e kind, input int size,
		input int addr, input logic [63:0] data, input bit uns, input int rd);
		vec_t v;
		v.name = name;
		v.kind = kind;
		v.size = size;
		v.addr = 64'(addr);
		v.data = data;
		v.is_unsigned = uns;
		v.rd = rd_tag_w'(rd);
		v.expected = (kind == k_store) ? 64'h0 : ref_load(size, addr, uns);
		if (kind != k_load) begin
			ref_store(size, addr, data);
		end
		vecs.push_back(v);
	endfunction

	task automatic build_table();
		// Known contents for 0x100 to 0x17f
		for (int k = 0; k < 16; k++) begin
			add_vec($sformatf("fill %0d", k), k_store, 3, 'h100 + 8*k, random_dword(), 0, 0);
		end
		// Each size stored then loaded back
		add_vec("sb", k_store, 0, 'h120, random_dword(), 0, 0);
		add_vec("lbu after sb", k_load, 0, 'h120, 0, 1, 1);
		add_vec("sh", k_store, 1, 'h122, random_dword(), 0, 0);
		add_vec("lh after sh", k_load, 1, 'h122, 0, 0, 2);
		add_vec("sw", k_store, 2, 'h124, random_dword(), 0, 0);
		add_vec("lw after sw", k_load, 2, 'h124, 0, 0, 3);
		add_vec("sd", k_store, 3, 'h128, random_dword(), 0, 0);
		add_vec("ld after sd", k_load, 3, 'h128, 0, 0, 4);
		// Extension with the top bit set and clear
		add_vec("sb neg", k_store, 0, 'h131, 64'ha5, 0, 0);
		add_vec("lb neg", k_load, 0, 'h131, 0, 0, 5);
		add_vec("lbu neg", k_load, 0, 'h131, 0, 1, 6);
		add_vec("sb pos", k_store, 0, 'h133, 64'h7f, 0, 0);
		add_vec("lb pos", k_load, 0, 'h133, 0, 0, 7);
		add_vec("sh neg", k_store, 1, 'h134, 64'h8001, 0, 0);
		add_vec("lh neg", k_load, 1, 'h134, 0, 0, 8);
		add_vec("lhu neg", k_load, 1, 'h134, 0, 1, 9);
		add_vec("sw neg", k_store, 2, 'h138, 64'hdeadbeef, 0, 0);
		add_vec("lw neg", k_load, 2, 'h138, 0, 0, 10);
		add_vec("lwu neg", k_load, 2, 'h138, 0, 1, 11);
		// Doubleword crossings with the neighbours read back whole
		add_vec("sh off7", k_store, 1, 'h147, random_dword(), 0, 0);
		add_vec("lh off7", k_load, 1, 'h147, 0, 0, 12);
		add_vec("ld below sh off7", k_load, 3, 'h140, 0, 0, 13);
		add_vec("ld above sh off7", k_load, 3, 'h148, 0, 0, 14);
		add_vec("sw off5", k_store, 2, 'h15d, random_dword(), 0, 0);
		add_vec("lw off5", k_load, 2, 'h15d, 0, 0, 15);
		add_vec("lwu off6", k_load, 2, 'h15e, 0, 1, 16);
		add_vec("ld below sw off5", k_load, 3, 'h158, 0, 0, 17);
		add_vec("ld above sw off5", k_load, 3, 'h160, 0, 0, 18);
		add_vec("sd off6", k_store, 3, 'h16e, random_dword(), 0, 0);
		add_vec("ld off6", k_load, 3, 'h16e, 0, 0, 19);
		add_vec("ld below sd off6", k_load, 3, 'h168, 0, 0, 20);
		add_vec("ld above sd off6", k_load, 3, 'h170, 0, 0, 21);
		add_vec("sd off7", k_store, 3, 'h10f, random_dword(), 0, 0);
		add_vec("ld off7", k_load, 3, 'h10f, 0, 0, 22);
		add_vec("ld below sd off7", k_load, 3, 'h108, 0, 0, 23);
		add_vec("ld above sd off7", k_load, 3, 'h110, 0, 0, 24);
		// Load and store together with the load first
		add_vec("pair ld", k_pair, 3, 'h178, random_dword(), 0, 25);
		add_vec("ld after pair ld", k_load, 3, 'h178, 0, 0, 26);
		add_vec("pair lw off5", k_pair, 2, 'h14d, random_dword(), 0, 27);
		add_vec("lw after pair lw", k_load, 2, 'h14d, 0, 0, 28);
	endtask

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_wb(input string name, input logic [63:0] rd, input logic [63:0] result);
		compare_value({name, " wb_valid"}, 64'h1, 64'(wb_valid));
		compare_value({name, " rd"}, rd, 64'(wb.rd));
		compare_value({name, " result"}, result, wb.result);
	endtask

	task automatic drive_load(input vec_t v);
		lu_req.op = load_op_e'(v.size);
		lu_req.rd = v.rd;
		lu_req.addr = v.addr;
		lu_req.is_unsigned = v.is_unsigned;
		lu_valid = 1'b1;
	endtask

	task automatic drive_store(input vec_t v);
		su_req.op = store_op_e'(v.size);
		su_req.addr = v.addr;
		su_req.data = v.data;
		su_valid = 1'b1;
	endtask

	// Return just after the edge that carries the handshake
	task automatic wait_load_transfer(output int edges);
		bit done;
		done = 1'b0;
		edges = 0;
		while (!done) begin
			@(posedge CLK);
			edges++;
			done = lu_valid && lu_ready;
		end
	endtask

	task automatic wait_store_transfer(output int edges);
		bit done;
		done = 1'b0;
		edges = 0;
		while (!done) begin
			@(posedge CLK);
			edges++;
			done = su_valid && su_ready;
		end
	endtask

	task automatic run_vec(input vec_t v);
		int edges;
		@(negedge CLK);
		// Nothing was accepted in the previous cycle
		compare_value({v.name, " idle wb_valid"}, 64'h0, 64'(wb_valid));
		case (v.kind)
			k_store: begin
				drive_store(v);
				wait_store_transfer(edges);
				// No load present, so the first edge takes it
				compare_value({v.name, " store wait"}, 64'h1, 64'(edges));
				@(negedge CLK);
				su_valid = 1'b0;
				check_wb(v.name, 64'h0, 64'h0);
			end
			k_load: begin
				drive_load(v);
				wait_load_transfer(edges);
				compare_value({v.name, " load wait"}, 64'h1, 64'(edges));
				@(negedge CLK);
				lu_valid = 1'b0;
				check_wb(v.name, 64'(v.rd), v.expected);
			end
			default: begin
				drive_load(v);
				drive_store(v);
				wait_load_transfer(edges);
				compare_value({v.name, " load wait"}, 64'h1, 64'(edges));
				compare_value({v.name, " su_ready"}, 64'h0, 64'(su_ready));
				@(negedge CLK);
				lu_valid = 1'b0;
				check_wb(v.name, 64'(v.rd), v.expected);
				// Store goes in the cycle after the load
				wait_store_transfer(edges);
				compare_value({v.name, " store wait"}, 64'h1, 64'(edges));
				@(negedge CLK);
				su_valid = 1'b0;
				check_wb({v.name, " store"}, 64'h0, 64'h0);
			end
		endcase
	endtask

	initial begin
		reset = 1'b1;
		lu_valid = 1'b0;
		su_valid = 1'b0;
		lu_req = '0;
		su_req = '0;
		build_table();
		cycle_limit = 20 * vecs.size() + 100;
		repeat (10) begin
			@(negedge CLK);
			compare_value("reset wb_valid", 64'h0, 64'(wb_valid));
		end
		reset = 1'b0;
		@(negedge CLK);
		compare_value("after reset wb_valid", 64'h0, 64'(wb_valid));
		compare_value("after reset lu_ready", 64'h1, 64'(lu_ready));
		for (int i = 0; i < vecs.size(); i++) begin
			run_vec(vecs[i]);
		end
		@(negedge CLK);
		compare_value("final wb_valid", 64'h0, 64'(wb_valid));
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: lsu_top.f
common/lsu_pkg.sv
source/dtcm.sv
lsu/store_align.sv
lsu/load_extract.sv
lsu/lsu.sv
source/lsu_top.sv
dv/lsu_tb.sv

// File: Makefile
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP ?= lsu_tb
FILELIST ?= lsu_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
